/* project.f */
+incdir+sim
verilog/lc4_pkg.sv
verilog/lc4_if.sv
verilog/lc4_fetch.sv
verilog/lc4_regfile.sv
verilog/lc4_decode_stage.sv
verilog/lc4_alu.sv
verilog/lc4_execute_stage.sv
verilog/lc4_mem_wb_stage.sv
verilog/lc4_pipeline_top.sv
sim/tb_lc4_pipeline.sv

/* run.sh */
#!/bin/sh
# Build and run the LC4 pipeline testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f project.f \
  --top-module tb_lc4_pipeline -o tb_lc4_pipeline
./obj_dir/tb_lc4_pipeline

/* sim/tb_program.svh */
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

// One expected retire, as seen on the W-stage trace ports
typedef struct packed {
  logic [15:0] pc;
  logic [15:0] insn;
  logic        rf_we;
  logic [2:0]  rf_sel;    // Only meaningful when rf_we
  logic [15:0] rf_data;
  logic        nzp_we;
  logic [2:0]  nzp;       // {N, Z, P}, only meaningful when nzp_we
} retire_row_t;

// Program image, word 0 sits at 16'h8200
localparam int PROG_LEN = 28;
localparam logic [15:0] PROG [PROG_LEN] = '{
  16'h9205,  // 8200 CONST R1, 5
  16'h95FD,  // 8201 CONST R2, -3
  16'h1642,  // 8202 ADD  R3, R1, R2   R2 from M, R1 from W
  16'h18D1,  // 8203 SUB  R4, R3, R1
  16'h5B1B,  // 8204 XOR  R5, R4, R3
  16'h5D66,  // 8205 AND  R6, R5, #6
  16'h5F92,  // 8206 OR   R7, R6, R2
  16'h1FE1,  // 8207 ADD  R7, R7, #1   Wraps to zero
  16'h9220,  // 8208 CONST R1, 32
  16'h7842,  // 8209 STR  R4, R1, #2   mem[0x22] = FFFD
  16'h6442,  // 820A LDR  R2, R1, #2
  16'h1681,  // 820B ADD  R3, R2, R1   Two-cycle load-use stall
  16'h6842,  // 820C LDR  R4, R1, #2
  16'h9A01,  // 820D CONST R5, 1
  16'h1D05,  // 820E ADD  R6, R4, R5   One-cycle stall, load in M
  16'h1DA2,  // 820F ADD  R6, R6, #2   Zero
  16'h0A01,  // 8210 BRnp +1           Not taken
  16'h1B7F,  // 8211 ADD  R5, R5, #-1  Zero
  16'h0401,  // 8212 BRz  +1           Taken
  16'h9E55,  // 8213 CONST R7, 0x55    Squashed
  16'h9E03,  // 8214 CONST R7, 3
  16'hC801,  // 8215 JMP  +1
  16'h9E66,  // 8216 CONST R7, 0x66    Squashed
  16'h621A,  // 8217 LDR  R1, R0, #26  Fill word is 821A
  16'hC040,  // 8218 JMPR R1           Stalls on the load first
  16'h9E44,  // 8219 CONST R7, 0x44    Squashed
  16'h15E1,  // 821A ADD  R2, R7, #1   R7 must still be 3
  16'h0FFF   // 821B BRnzp -1          Spin here
};

// Retires in order, squashed words never show up
localparam int ROW_COUNT = 26;
localparam retire_row_t EXPECT_ROWS [ROW_COUNT] = '{
  '{16'h8200, 16'h9205, 1'b1, 3'd1, 16'h0005, 1'b1, 3'b001},
  '{16'h8201, 16'h95FD, 1'b1, 3'd2, 16'hFFFD, 1'b1, 3'b100},
  '{16'h8202, 16'h1642, 1'b1, 3'd3, 16'h0002, 1'b1, 3'b001},
  '{16'h8203, 16'h18D1, 1'b1, 3'd4, 16'hFFFD, 1'b1, 3'b100},
  '{16'h8204, 16'h5B1B, 1'b1, 3'd5, 16'hFFFF, 1'b1, 3'b100},
  '{16'h8205, 16'h5D66, 1'b1, 3'd6, 16'h0006, 1'b1, 3'b001},
  '{16'h8206, 16'h5F92, 1'b1, 3'd7, 16'hFFFF, 1'b1, 3'b100},
  '{16'h8207, 16'h1FE1, 1'b1, 3'd7, 16'h0000, 1'b1, 3'b010},
  '{16'h8208, 16'h9220, 1'b1, 3'd1, 16'h0020, 1'b1, 3'b001},
  '{16'h8209, 16'h7842, 1'b0, 3'd0, 16'h0000, 1'b0, 3'b000},  // Store
  '{16'h820A, 16'h6442, 1'b1, 3'd2, 16'hFFFD, 1'b1, 3'b100},
  '{16'h820B, 16'h1681, 1'b1, 3'd3, 16'h001D, 1'b1, 3'b001},
  '{16'h820C, 16'h6842, 1'b1, 3'd4, 16'hFFFD, 1'b1, 3'b100},
  '{16'h820D, 16'h9A01, 1'b1, 3'd5, 16'h0001, 1'b1, 3'b001},
  '{16'h820E, 16'h1D05, 1'b1, 3'd6, 16'hFFFE, 1'b1, 3'b100},
  '{16'h820F, 16'h1DA2, 1'b1, 3'd6, 16'h0000, 1'b1, 3'b010},
  '{16'h8210, 16'h0A01, 1'b0, 3'd0, 16'h0000, 1'b0, 3'b000},
  '{16'h8211, 16'h1B7F, 1'b1, 3'd5, 16'h0000, 1'b1, 3'b010},
  '{16'h8212, 16'h0401, 1'b0, 3'd0, 16'h0000, 1'b0, 3'b000},
  '{16'h8214, 16'h9E03, 1'b1, 3'd7, 16'h0003, 1'b1, 3'b001},
  '{16'h8215, 16'hC801, 1'b0, 3'd0, 16'h0000, 1'b0, 3'b000},
  '{16'h8217, 16'h621A, 1'b1, 3'd1, 16'h821A, 1'b1, 3'b100},
  '{16'h8218, 16'hC040, 1'b0, 3'd0, 16'h0000, 1'b0, 3'b000},
  '{16'h821A, 16'h15E1, 1'b1, 3'd2, 16'h0004, 1'b1, 3'b001},
  '{16'h821B, 16'h0FFF, 1'b0, 3'd0, 16'h0000, 1'b0, 3'b000},
  '{16'h821B, 16'h0FFF, 1'b0, 3'd0, 16'h0000, 1'b0, 3'b000}   // Second lap of the spin
};

`endif

/* sim/tb_lc4_pipeline.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_lc4_pipeline;

  localparam int RETIRE_TIMEOUT = 20;   // Cycles allowed from one retire to the next

  `include "tb_program.svh"

  logic        gwe             = 1'b0;
  logic        i_arst_n        = 1'b0;
  logic [15:0] i_cur_insn      = 16'h0000;
  logic [15:0] i_cur_dmem_data = 16'h0000;

  wire [15:0] o_cur_pc, o_dmem_addr, o_dmem_towrite;
  wire [15:0] o_wb_pc, o_wb_insn, o_regfile_data;
  wire        o_dmem_we, o_wb_valid, o_regfile_we, o_nzp_we;
  wire [2:0]  o_regfile_wsel, o_nzp_bits;

  logic [15:0] dmem [256];
  logic [15:0] prev_dmem_addr = 16'h0000;   // M-stage address one cycle back
  logic        prev_dmem_we   = 1'b0;

  always #5 gwe = ~gwe;   // 10 ns period

  lc4_pipeline_top dut_i (
    .gwe             (gwe),
    .i_arst_n        (i_arst_n),
    .i_cur_insn      (i_cur_insn),
    .i_cur_dmem_data (i_cur_dmem_data),
    .o_cur_pc        (o_cur_pc),
    .o_dmem_addr     (o_dmem_addr),
    .o_dmem_we       (o_dmem_we),
    .o_dmem_towrite  (o_dmem_towrite),
    .o_wb_valid      (o_wb_valid),
    .o_wb_pc         (o_wb_pc),
    .o_wb_insn       (o_wb_insn),
    .o_regfile_we    (o_regfile_we),
    .o_regfile_wsel  (o_regfile_wsel),
    .o_regfile_data  (o_regfile_data),
    .o_nzp_we        (o_nzp_we),
    .o_nzp_bits      (o_nzp_bits)
  );

  function automatic logic [15:0] imem_word(input logic [15:0] pc);
    logic [15:0] off;
    off = pc - 16'h8200;
    if (off < 16'(PROG_LEN)) begin
      return PROG[off[4:0]];
    end
    return 16'h0000;   // BR with an empty mask acts as a NOP
  endfunction

  // Every word differs and is a legal code address
  function automatic logic [15:0] dmem_fill(input logic [7:0] a);
    return 16'h8200 + {8'h00, a};
  endfunction

  function automatic logic is_mem_op(input logic [15:0] insn);
    return (insn[15:12] == 4'h6) || (insn[15:12] == 4'h7);   // LDR or STR
  endfunction

  // Synchronous imem whose word lands with the D-stage PC
  always @(posedge gwe) begin
    i_cur_insn <= imem_word(o_cur_pc);
  end

  // Synchronous dmem where a read returns the old word on a same-edge write
  always @(posedge gwe) begin
    if (!i_arst_n) begin
      for (int a = 0; a < 256; a++) begin
        dmem[a] <= dmem_fill(8'(a));
      end
    end else begin
      if (o_dmem_we) begin
        dmem[o_dmem_addr[7:0]] <= o_dmem_towrite;
      end
      i_cur_dmem_data <= dmem[o_dmem_addr[7:0]];
    end
  end

  task automatic check_value(input string name, input logic [15:0] expected,
                             input logic [15:0] actual);
    if (actual !== expected) begin
      $display("FAILED %s: expected %h, actual %h", name, expected, actual);
      $display("Finished with errors");
      $fatal(1);
    end
  endtask

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Finished with errors");
    $fatal(1);
  endtask

  // Next negedge with a retire on the trace
  task automatic wait_retire(input int row);
    int cycles;
    cycles = 0;
    @(negedge gwe);
    while (!o_wb_valid) begin
      cycles++;
      if (cycles > RETIRE_TIMEOUT) begin
        abort_run($sformatf("Timed out waiting for retire row %0d", row));
      end
      @(negedge gwe);
    end
  endtask

  task automatic check_row(input int row);
    retire_row_t want;
    want = EXPECT_ROWS[row];
    check_value($sformatf("row %0d pc", row), want.pc, o_wb_pc);
    check_value($sformatf("row %0d insn", row), want.insn, o_wb_insn);
    check_value($sformatf("row %0d regfile_we", row), 16'(want.rf_we), 16'(o_regfile_we));
    if (want.rf_we) begin
      check_value($sformatf("row %0d regfile_wsel", row), 16'(want.rf_sel),
                  16'(o_regfile_wsel));
      check_value($sformatf("row %0d regfile_data", row), want.rf_data, o_regfile_data);
    end
    check_value($sformatf("row %0d nzp_we", row), 16'(want.nzp_we), 16'(o_nzp_we));
    if (want.nzp_we) begin
      check_value($sformatf("row %0d nzp_bits", row), 16'(want.nzp), 16'(o_nzp_bits));
    end
  endtask

  // The insn now in W was in M last cycle, so it owns that cycle's dmem address
  always @(negedge gwe) begin
    if (i_arst_n) begin
      if (!(o_wb_valid && is_mem_op(o_wb_insn))) begin
        check_value("dmem_addr idle", 16'h0000, prev_dmem_addr);
      end
      if (!(o_wb_valid && (o_wb_insn[15:12] == 4'h7))) begin
        check_value("dmem_we idle", 16'h0000, 16'(prev_dmem_we));   // Only STR writes
      end
    end
    prev_dmem_addr <= o_dmem_addr;
    prev_dmem_we   <= o_dmem_we;
  end

  initial begin
    repeat (3) @(posedge gwe);
    i_arst_n <= 1'b1;   // Out of reset after three edges
    for (int row = 0; row < ROW_COUNT; row++) begin
      wait_retire(row);
      check_row(row);
    end
    $display("Finished with no errors");
    $finish;
  end

endmodule

`default_nettype wire

/* verilog/lc4_pipeline_top.sv */
`timescale 1ns/1ps
`default_nettype none

module lc4_pipeline_top #(
  parameter lc4_pkg::word_t p_reset_pc = lc4_pkg::RESET_PC_DEFAULT
) (
  input  wire                    gwe,
  input  wire                    i_arst_n,
  input  wire lc4_pkg::word_t    i_cur_insn,        // Imem data, one cycle after o_cur_pc
  input  wire lc4_pkg::word_t    i_cur_dmem_data,   // Dmem data, one cycle after o_dmem_addr
  output wire lc4_pkg::word_t    o_cur_pc,
  output wire lc4_pkg::word_t    o_dmem_addr,
  output wire                    o_dmem_we,
  output wire lc4_pkg::word_t    o_dmem_towrite,
  output wire                    o_wb_valid,        // Retire trace
  output wire lc4_pkg::word_t    o_wb_pc,
  output wire lc4_pkg::word_t    o_wb_insn,
  output wire                    o_regfile_we,
  output wire lc4_pkg::reg_idx_t o_regfile_wsel,
  output wire lc4_pkg::word_t    o_regfile_data,
  output wire                    o_nzp_we,
  output wire lc4_pkg::nzp_t     o_nzp_bits
);

  wire lc4_pkg::word_t d_pc, target;
  wire                 d_valid, stall, redirect;

  lc4_dx_if  dx_bus  ();
  lc4_xm_if  xm_bus  ();
  lc4_fwd_if fwd_bus ();

  lc4_fetch #(
    .p_reset_pc (p_reset_pc)
  ) fetch_i (
    .gwe        (gwe),
    .i_arst_n   (i_arst_n),
    .i_stall    (stall),
    .i_redirect (redirect),
    .i_target   (target),
    .o_cur_pc   (o_cur_pc),
    .o_d_pc     (d_pc),
    .o_d_valid  (d_valid)
  );

  lc4_decode_stage decode_i (
    .gwe        (gwe),
    .i_arst_n   (i_arst_n),
    .i_d_pc     (d_pc),
    .i_d_valid  (d_valid),
    .i_insn     (i_cur_insn),
    .i_redirect (redirect),
    .i_wb_we    (o_regfile_we),
    .i_wb_rd    (o_regfile_wsel),
    .i_wb_data  (o_regfile_data),
    .fwd        (fwd_bus.sink),
    .dx         (dx_bus.src),
    .o_stall    (stall)
  );

  lc4_execute_stage execute_i (
    .gwe        (gwe),
    .i_arst_n   (i_arst_n),
    .dx         (dx_bus.dst),
    .fwd        (fwd_bus.sink),
    .xm         (xm_bus.src),
    .o_redirect (redirect),
    .o_target   (target)
  );

  lc4_mem_wb_stage mem_wb_i (
    .gwe             (gwe),
    .i_arst_n        (i_arst_n),
    .xm              (xm_bus.dst),
    .i_cur_dmem_data (i_cur_dmem_data),
    .fwd             (fwd_bus.src),
    .o_dmem_addr     (o_dmem_addr),
    .o_dmem_we       (o_dmem_we),
    .o_dmem_towrite  (o_dmem_towrite),
    .o_wb_we         (o_regfile_we),
    .o_wb_rd         (o_regfile_wsel),
    .o_wb_data       (o_regfile_data),
    .o_wb_valid      (o_wb_valid),
    .o_wb_pc         (o_wb_pc),
    .o_wb_insn       (o_wb_insn),
    .o_nzp_we        (o_nzp_we),
    .o_nzp_bits      (o_nzp_bits)
  );

endmodule

`default_nettype wire

/* verilog/lc4_mem_wb_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module lc4_mem_wb_stage (
  input  wire                 gwe,
  input  wire                 i_arst_n,
  lc4_xm_if.dst               xm,
  input  wire lc4_pkg::word_t i_cur_dmem_data,
  lc4_fwd_if.src              fwd,
  output lc4_pkg::word_t      o_dmem_addr,
  output logic                o_dmem_we,
  output lc4_pkg::word_t      o_dmem_towrite,
  output logic                o_wb_we,
  output lc4_pkg::reg_idx_t   o_wb_rd,
  output lc4_pkg::word_t      o_wb_data,
  output logic                o_wb_valid,
  output lc4_pkg::word_t      o_wb_pc,
  output lc4_pkg::word_t      o_wb_insn,
  output logic                o_nzp_we,
  output lc4_pkg::nzp_t       o_nzp_bits
);

  logic           w_rd_we, w_nzp_we, w_is_load;
  lc4_pkg::word_t w_result;
  lc4_pkg::nzp_t  nzp_q;

  // Dmem driven straight from M with read data landing in W
  assign o_dmem_addr    = (xm.valid && (xm.is_load || xm.is_store)) ? xm.result : '0;
  assign o_dmem_we      = xm.valid && xm.is_store;
  assign o_dmem_towrite = xm.store_data;

  always_ff @(posedge gwe or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_wb_valid <= 1'b0;
    end else begin
      o_wb_valid <= xm.valid;
    end
  end

  always_ff @(posedge gwe) begin
    o_wb_pc   <= xm.pc;
    o_wb_insn <= xm.insn;
    o_wb_rd   <= xm.rd;
    w_rd_we   <= xm.rd_we;
    w_nzp_we  <= xm.nzp_we;
    w_is_load <= xm.is_load;
    w_result  <= xm.result;
  end

  assign o_wb_data  = w_is_load ? i_cur_dmem_data : w_result;
  assign o_wb_we    = o_wb_valid && w_rd_we;
  assign o_nzp_we   = o_wb_valid && w_nzp_we;
  assign o_nzp_bits = lc4_pkg::nzp_of(o_wb_data);

  always_ff @(posedge gwe or negedge i_arst_n) begin
    if (!i_arst_n) begin
      nzp_q <= '0;
    end else if (o_nzp_we) begin
      nzp_q <= o_nzp_bits;         // Commit flags at retire
    end
  end

  assign fwd.m_valid   = xm.valid;
  assign fwd.m_rd      = xm.rd;
  assign fwd.m_rd_we   = xm.rd_we;
  assign fwd.m_nzp_we  = xm.nzp_we;
  assign fwd.m_is_load = xm.is_load;
  assign fwd.m_value   = xm.result;     // Not load data yet
  assign fwd.w_valid   = o_wb_valid;
  assign fwd.w_rd      = o_wb_rd;
  assign fwd.w_rd_we   = w_rd_we;
  assign fwd.w_nzp_we  = w_nzp_we;
  assign fwd.w_value   = o_wb_data;
  assign fwd.nzp       = nzp_q;

  // A store retires next cycle with no register or flag write
  a_store_retires: assert property (@(posedge gwe) disable iff (!i_arst_n)
    o_dmem_we |=> !o_wb_we && !o_nzp_we);

endmodule

`default_nettype wire

/* verilog/lc4_execute_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module lc4_execute_stage (
  input  wire            gwe,
  input  wire            i_arst_n,
  lc4_dx_if.dst          dx,
  lc4_fwd_if.sink        fwd,
  lc4_xm_if.src          xm,
  output logic           o_redirect,
  output lc4_pkg::word_t o_target
);

  lc4_pkg::word_t rs_val, rt_val, alu_b, alu_result;
  lc4_pkg::nzp_t  flags;
  logic m_rs, m_rt, w_rs, w_rt;
  logic taken, rs_used, rt_used;

  // Bypass hits, M is younger so it wins
  assign m_rs = fwd.m_valid && fwd.m_rd_we && (fwd.m_rd == dx.rs);
  assign m_rt = fwd.m_valid && fwd.m_rd_we && (fwd.m_rd == dx.rt);
  assign w_rs = fwd.w_valid && fwd.w_rd_we && (fwd.w_rd == dx.rs);
  assign w_rt = fwd.w_valid && fwd.w_rd_we && (fwd.w_rd == dx.rt);

  assign rs_val = m_rs ? fwd.m_value : (w_rs ? fwd.w_value : dx.rs_data);
  assign rt_val = m_rt ? fwd.m_value : (w_rt ? fwd.w_value : dx.rt_data);
  assign alu_b  = dx.use_imm ? dx.imm : rt_val;

  lc4_alu alu_i (
    .i_op     (dx.alu_op),
    .i_a      (rs_val),
    .i_b      (alu_b),
    .o_result (alu_result)
  );

  // Freshest flags along the same priority as the data bypass
  assign flags = (fwd.m_valid && fwd.m_nzp_we) ? lc4_pkg::nzp_of(fwd.m_value) :
                 (fwd.w_valid && fwd.w_nzp_we) ? lc4_pkg::nzp_of(fwd.w_value) :
                                                 fwd.nzp;
  assign taken = dx.is_branch && |(dx.insn[11:9] & flags);

  assign o_redirect = dx.valid && (taken || dx.is_jmp || dx.is_jmpr);
  assign o_target   = dx.is_jmpr ? rs_val : dx.pc + 16'd1 + dx.imm;   // PC-relative otherwise

  always_ff @(posedge gwe or negedge i_arst_n) begin
    if (!i_arst_n) begin
      xm.valid <= 1'b0;
    end else begin
      xm.valid <= dx.valid;
    end
  end

  always_ff @(posedge gwe) begin
    xm.pc         <= dx.pc;
    xm.insn       <= dx.insn;
    xm.rd         <= dx.rd;
    xm.rd_we      <= dx.rd_we;
    xm.nzp_we     <= dx.nzp_we;
    xm.is_load    <= dx.is_load;
    xm.is_store   <= dx.is_store;
    xm.result     <= alu_result;
    xm.store_data <= rt_val;      // STR data after bypass
  end

  // Which source fields the insn in X really reads
  assign rs_used = dx.is_jmpr || dx.is_store ||
                   (dx.rd_we && (dx.insn[15:12] != lc4_pkg::OP_CONST));
  assign rt_used = dx.is_store || (dx.rd_we && !dx.use_imm);

  // Decode must have held back anything that would pick up an address as load data
  a_no_load_fwd: assert property (@(posedge gwe) disable iff (!i_arst_n)
    dx.valid && ((rs_used && m_rs) || (rt_used && m_rt) ||
                 (dx.is_branch && fwd.m_valid && fwd.m_nzp_we))
    |-> !fwd.m_is_load);

endmodule

`default_nettype wire

/* verilog/lc4_alu.sv */
`timescale 1ns/1ps
`default_nettype none

module lc4_alu (
  input  wire lc4_pkg::alu_op_t i_op,
  input  wire lc4_pkg::word_t   i_a,
  input  wire lc4_pkg::word_t   i_b,
  output lc4_pkg::word_t        o_result
);

  always_comb begin
    case (i_op)
      lc4_pkg::ALU_ADD:   o_result = i_a + i_b;   // Also LDR/STR address
      lc4_pkg::ALU_SUB:   o_result = i_a - i_b;
      lc4_pkg::ALU_AND:   o_result = i_a & i_b;
      lc4_pkg::ALU_OR:    o_result = i_a | i_b;
      lc4_pkg::ALU_XOR:   o_result = i_a ^ i_b;
      lc4_pkg::ALU_PASSB: o_result = i_b;
      default:            o_result = '0;
    endcase
  end

endmodule

`default_nettype wire

/* verilog/lc4_decode_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module lc4_decode_stage (
  input  wire                    gwe,
  input  wire                    i_arst_n,
  input  wire lc4_pkg::word_t    i_d_pc,
  input  wire                    i_d_valid,
  input  wire lc4_pkg::word_t    i_insn,
  input  wire                    i_redirect,
  input  wire                    i_wb_we,
  input  wire lc4_pkg::reg_idx_t i_wb_rd,
  input  wire lc4_pkg::word_t    i_wb_data,
  lc4_fwd_if.sink                fwd,
  lc4_dx_if.src                  dx,
  output logic                   o_stall
);

  lc4_pkg::opcode_t  opcode;
  lc4_pkg::reg_idx_t rs, rt, rd;
  lc4_pkg::word_t    rs_data, rt_data, imm;
  lc4_pkg::alu_op_t  alu_op;
  logic rs_re, rt_re, rd_we, use_imm;
  logic is_load, is_store, is_branch, is_jmpr, is_jmp;
  logic x_hit, m_hit;

  assign opcode = i_insn[15:12];
  assign rs     = i_insn[8:6];
  assign rd     = i_insn[11:9];
  assign rt     = (opcode == lc4_pkg::OP_STR) ? i_insn[11:9] : i_insn[2:0];  // STR data reg

  lc4_regfile regfile_i (
    .gwe       (gwe),
    .i_arst_n  (i_arst_n),
    .i_rs      (rs),
    .i_rt      (rt),
    .i_rd      (i_wb_rd),
    .i_we      (i_wb_we),
    .i_wdata   (i_wb_data),
    .o_rs_data (rs_data),
    .o_rt_data (rt_data)
  );

  always_comb begin
    rs_re     = 1'b0;
    rt_re     = 1'b0;
    rd_we     = 1'b0;
    use_imm   = 1'b0;
    is_load   = 1'b0;
    is_store  = 1'b0;
    is_branch = 1'b0;
    is_jmpr   = 1'b0;
    is_jmp    = 1'b0;
    alu_op    = lc4_pkg::ALU_ADD;
    imm       = {{11{i_insn[4]}}, i_insn[4:0]};    // imm5 of the ALU forms
    case (opcode)
      lc4_pkg::OP_BR: begin
        is_branch = 1'b1;
        imm       = {{7{i_insn[8]}}, i_insn[8:0]};
      end
      lc4_pkg::OP_ARITH: begin
        rd_we   = i_insn[5] || !i_insn[3];        // MUL and DIV become no-ops
        rs_re   = rd_we;
        rt_re   = !i_insn[5] && !i_insn[3];
        use_imm = i_insn[5];
        alu_op  = rt_re && i_insn[4] ? lc4_pkg::ALU_SUB : lc4_pkg::ALU_ADD;
      end
      lc4_pkg::OP_LOGIC: begin
        rd_we   = i_insn[5] || (i_insn[4:3] != 2'b01);   // NOT dropped
        rs_re   = rd_we;
        rt_re   = rd_we && !i_insn[5];
        use_imm = i_insn[5];
        alu_op  = (i_insn[5] || !i_insn[4]) ? lc4_pkg::ALU_AND :
                  (i_insn[3] ? lc4_pkg::ALU_XOR : lc4_pkg::ALU_OR);
      end
      lc4_pkg::OP_LDR, lc4_pkg::OP_STR: begin
        is_load  = (opcode == lc4_pkg::OP_LDR);
        is_store = !is_load;
        rd_we    = is_load;
        rs_re    = 1'b1;                           // Base register
        rt_re    = is_store;
        use_imm  = 1'b1;
        imm      = {{10{i_insn[5]}}, i_insn[5:0]};
      end
      lc4_pkg::OP_CONST: begin
        rd_we   = 1'b1;
        use_imm = 1'b1;
        alu_op  = lc4_pkg::ALU_PASSB;
        imm     = {{7{i_insn[8]}}, i_insn[8:0]};
      end
      lc4_pkg::OP_JMP: begin
        is_jmp  = i_insn[11];
        is_jmpr = !i_insn[11];
        rs_re   = is_jmpr;
        imm     = {{5{i_insn[10]}}, i_insn[10:0]};
      end
      default: begin
        // Everything else retires as a no-op
      end
    endcase
  end

  // Load data only exists in W, so D waits out a load in X or M it depends on
  assign x_hit = dx.valid && dx.is_load &&
                 ((rs_re && dx.rd == rs) || (rt_re && dx.rd == rt) || is_branch);
  assign m_hit = fwd.m_valid && fwd.m_is_load &&
                 ((rs_re && fwd.m_rd == rs) || (rt_re && fwd.m_rd == rt) || is_branch);
  assign o_stall = i_d_valid && (x_hit || m_hit);

  always_ff @(posedge gwe or negedge i_arst_n) begin
    if (!i_arst_n) begin
      dx.valid <= 1'b0;
    end else begin
      dx.valid <= i_d_valid && !o_stall && !i_redirect;   // Bubble on stall or squash
    end
  end

  // Payload follows D every cycle and valid says whether it counts
  always_ff @(posedge gwe) begin
    dx.pc        <= i_d_pc;
    dx.insn      <= i_insn;
    dx.rs        <= rs;
    dx.rt        <= rt;
    dx.rd        <= rd;
    dx.rs_data   <= rs_data;
    dx.rt_data   <= rt_data;
    dx.rd_we     <= rd_we;
    dx.nzp_we    <= rd_we;       // Every register write sets NZP
    dx.is_load   <= is_load;
    dx.is_store  <= is_store;
    dx.is_branch <= is_branch;
    dx.is_jmpr   <= is_jmpr;
    dx.is_jmp    <= is_jmp;
    dx.alu_op    <= alu_op;
    dx.use_imm   <= use_imm;
    dx.imm       <= imm;
  end

  // A load ahead of D reaches W within two cycles, so no stall runs three cycles
  a_stall_bound: assert property (@(posedge gwe) disable iff (!i_arst_n)
    o_stall && $past(o_stall) |=> !o_stall);

endmodule

`default_nettype wire

/* verilog/lc4_regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module lc4_regfile (
  input  wire                    gwe,
  input  wire                    i_arst_n,
  input  wire lc4_pkg::reg_idx_t i_rs,
  input  wire lc4_pkg::reg_idx_t i_rt,
  input  wire lc4_pkg::reg_idx_t i_rd,
  input  wire                    i_we,
  input  wire lc4_pkg::word_t    i_wdata,
  output lc4_pkg::word_t         o_rs_data,
  output lc4_pkg::word_t         o_rt_data
);

  lc4_pkg::word_t regs [8];

  always_ff @(posedge gwe or negedge i_arst_n) begin
    if (!i_arst_n) begin
      for (int i = 0; i < 8; i++) begin
        regs[i] <= '0;
      end
    end else if (i_we) begin
      regs[i_rd] <= i_wdata;
    end
  end

  // Write-through so D sees the value W is committing this cycle
  assign o_rs_data = (i_we && (i_rd == i_rs)) ? i_wdata : regs[i_rs];
  assign o_rt_data = (i_we && (i_rd == i_rt)) ? i_wdata : regs[i_rt];

endmodule

`default_nettype wire

/* verilog/lc4_fetch.sv */
`timescale 1ns/1ps
`default_nettype none

module lc4_fetch #(
  parameter lc4_pkg::word_t p_reset_pc = lc4_pkg::RESET_PC_DEFAULT
) (
  input  wire                 gwe,
  input  wire                 i_arst_n,
  input  wire                 i_stall,
  input  wire                 i_redirect,
  input  wire lc4_pkg::word_t i_target,
  output lc4_pkg::word_t      o_cur_pc,
  output lc4_pkg::word_t      o_d_pc,
  output logic                o_d_valid
);

  // Priority: redirect, then stall, then reset vector, then sequential
  assign o_cur_pc = i_redirect ? i_target :
                    i_stall    ? o_d_pc :            // Refetch the held insn
                    !o_d_valid ? p_reset_pc :        // First fetch out of reset
                                 o_d_pc + 16'd1;

  // PC of the word imem hands back next cycle
  always_ff @(posedge gwe or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_d_pc    <= '0;
      o_d_valid <= 1'b0;
    end else begin
      o_d_pc    <= o_cur_pc;
      o_d_valid <= 1'b1;   // Target insn after a redirect is real, X squashes the old one
    end
  end

endmodule

`default_nettype wire

/* verilog/lc4_if.sv */
`timescale 1ns/1ps
`default_nettype none

// Decoded insn sitting in X
interface lc4_dx_if;
  logic              valid;
  lc4_pkg::word_t    pc, insn;
  lc4_pkg::reg_idx_t rs, rt, rd;
  lc4_pkg::word_t    rs_data, rt_data;   // Regfile values read in D
  logic              rd_we, nzp_we, is_load, is_store, is_branch, is_jmpr, is_jmp;
  lc4_pkg::alu_op_t  alu_op;
  logic              use_imm;            // ALU B from imm instead of rt
  lc4_pkg::word_t    imm;                // Already sign extended

  modport src (output valid, pc, insn, rs, rt, rd, rs_data, rt_data, rd_we, nzp_we,
               is_load, is_store, is_branch, is_jmpr, is_jmp, alu_op, use_imm, imm);
  modport dst (input valid, pc, insn, rs, rt, rd, rs_data, rt_data, rd_we, nzp_we,
               is_load, is_store, is_branch, is_jmpr, is_jmp, alu_op, use_imm, imm);
endinterface

// Insn sitting in M
interface lc4_xm_if;
  logic              valid;
  lc4_pkg::word_t    pc, insn;
  lc4_pkg::reg_idx_t rd;
  logic              rd_we, nzp_we, is_load, is_store;
  lc4_pkg::word_t    result;      // ALU output, doubles as dmem address
  lc4_pkg::word_t    store_data;  // Bypassed rt

  modport src (output valid, pc, insn, rd, rd_we, nzp_we, is_load, is_store,
               result, store_data);
  modport dst (input valid, pc, insn, rd, rd_we, nzp_we, is_load, is_store,
               result, store_data);
endinterface

// What M and W show back to X and D
interface lc4_fwd_if;
  logic              m_valid, m_rd_we, m_nzp_we, m_is_load;
  lc4_pkg::reg_idx_t m_rd;
  lc4_pkg::word_t    m_value;    // M-stage ALU result
  logic              w_valid, w_rd_we, w_nzp_we;
  lc4_pkg::reg_idx_t w_rd;
  lc4_pkg::word_t    w_value;    // Final writeback value
  lc4_pkg::nzp_t     nzp;        // Committed flags

  modport src  (output m_valid, m_rd, m_rd_we, m_nzp_we, m_is_load, m_value,
                w_valid, w_rd, w_rd_we, w_nzp_we, w_value, nzp);
  modport sink (input m_valid, m_rd, m_rd_we, m_nzp_we, m_is_load, m_value,
                w_valid, w_rd, w_rd_we, w_nzp_we, w_value, nzp);
endinterface

`default_nettype wire

/* verilog/lc4_pkg.sv */
`default_nettype none

package lc4_pkg;

  typedef logic [15:0] word_t;     // Data word or memory address
  typedef logic [2:0]  reg_idx_t;  // R0..R7
  typedef logic [2:0]  nzp_t;      // {N, Z, P}
  typedef logic [3:0]  opcode_t;   // insn[15:12]
  typedef logic [2:0]  alu_op_t;

  // Opcodes of the supported subset
  localparam opcode_t OP_BR    = 4'h0;  // Also NOP when the mask is 000
  localparam opcode_t OP_ARITH = 4'h1;
  localparam opcode_t OP_LOGIC = 4'h5;
  localparam opcode_t OP_LDR   = 4'h6;
  localparam opcode_t OP_STR   = 4'h7;
  localparam opcode_t OP_CONST = 4'h9;
  localparam opcode_t OP_JMP   = 4'hC;  // insn[11] picks JMP over JMPR

  localparam alu_op_t ALU_ADD   = 3'd0;
  localparam alu_op_t ALU_SUB   = 3'd1;
  localparam alu_op_t ALU_AND   = 3'd2;
  localparam alu_op_t ALU_OR    = 3'd3;
  localparam alu_op_t ALU_XOR   = 3'd4;
  localparam alu_op_t ALU_PASSB = 3'd5;  // CONST goes straight through

  localparam word_t RESET_PC_DEFAULT = 16'h8200;  // Start of user code

  // Condition codes of a value written to a register
  function automatic nzp_t nzp_of(word_t v);
    return {v[15], v == 16'h0000, !v[15] && (v != 16'h0000)};
  endfunction

endpackage

`default_nettype wire
